// File: all.f
rtl/lsu_pkg.sv
rtl/load_beat_if.sv
rtl/load_fsm.sv
rtl/beat_counter.sv
rtl/load_addr_gen.sv
rtl/burst_buffer.sv
rtl/scratch_sram.sv
rtl/load_unit_top.sv
verification/axi_dram_model.sv
verification/load_unit_tb.sv

// File: rtl/beat_counter.sv
`timescale 1ns/1ns

module beat_counter #(
    parameter int BURST_MAX = 16,
    parameter int MAX_RETRY = 3
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         clear_beats,
    input  logic                         start,
    input  logic                         beat_fire,
    input  logic                         commit_en,
    input  logic                         reissue,
    input  lsu_pkg::len_t                len_q,
    output logic [$clog2(BURST_MAX)-1:0] slot,
    output logic                         commit_last,
    output logic                         retry_exhausted
);

    localparam int SW = $clog2(BURST_MAX);
    localparam int RW = $clog2(MAX_RETRY + 2);
    localparam logic [SW-1:0] SLOT_MAX = SW'(BURST_MAX - 1);

    logic [SW-1:0] last_slot;
    logic [RW-1:0] retry_cnt;

    // lengths past the buffer depth are clipped
    assign last_slot = (len_q > 8'(BURST_MAX - 1)) ? SLOT_MAX : len_q[SW-1:0];

    assign commit_last     = commit_en && (slot == last_slot);
    assign retry_exhausted = (retry_cnt >= RW'(MAX_RETRY));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot      <= '0;
            retry_cnt <= '0;
        end else begin
            if (start || clear_beats) begin
                slot <= '0;
            end else if ((beat_fire || commit_en) && (slot != SLOT_MAX)) begin
                slot <= slot + 1'b1;
            end

            if (start) begin
                retry_cnt <= '0;
            end else if (reissue) begin
                retry_cnt <= retry_cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/burst_buffer.sv
`timescale 1ns/1ns

module burst_buffer #(
    parameter int BURST_MAX = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         capture,
    input  lsu_pkg::saddr_t              cmd_sram_addr,
    input  lsu_pkg::bank_t               cmd_sram_bank,
    input  logic                         clear_beats,
    input  logic                         commit_en,
    input  logic [$clog2(BURST_MAX)-1:0] slot,
    load_beat_if.buf_mp                  beat,
    output logic                         burst_bad,
    output logic                         sram_we,
    output lsu_pkg::bank_t               sram_bank,
    output lsu_pkg::saddr_t              sram_addr,
    output lsu_pkg::word_t               sram_wdata
);
    import lsu_pkg::*;

    word_t  buf_mem [BURST_MAX];
    saddr_t base_q;
    bank_t  bank_q;
    logic   bad_q;
    logic   fire;
    logic   beat_bad;

    assign fire     = beat.rvalid && beat.rready;
    assign beat_bad = fire && (beat.rresp != RESP_OKAY);

    // includes the beat on the bus so the last beat counts too
    assign burst_bad = bad_q || beat_bad;

    assign sram_we    = commit_en;
    assign sram_bank  = bank_q;
    assign sram_addr  = base_q + saddr_t'(slot);
    assign sram_wdata = buf_mem[slot];

    always_ff @(posedge clk) begin
        if (capture) begin
            base_q <= cmd_sram_addr;
            bank_q <= cmd_sram_bank;
        end
        if (fire) begin
            buf_mem[slot] <= beat.rdata;
        end
    end

    // sticky over one attempt, dropped at the end of each burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bad_q <= 1'b0;
        end else if (clear_beats) begin
            bad_q <= 1'b0;
        end else if (beat_bad) begin
            bad_q <= 1'b1;
        end
    end

endmodule

// File: rtl/load_addr_gen.sv
`timescale 1ns/1ns

module load_addr_gen (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            capture,
    input  logic            reissue,
    input  lsu_pkg::id_t    cmd_id,
    input  lsu_pkg::daddr_t cmd_addr,
    input  lsu_pkg::len_t   cmd_len,
    input  lsu_pkg::size_t  cmd_size,
    input  logic            arready,
    output logic            arvld,
    output lsu_pkg::id_t    arid,
    output lsu_pkg::daddr_t araddr,
    output lsu_pkg::len_t   arlen,
    output lsu_pkg::size_t  arsize,
    output logic            ar_done,
    output lsu_pkg::len_t   len_q
);

    assign ar_done = arvld && arready;
    assign len_q   = arlen;

    // request fields only move on a new command, a retry reuses them
    always_ff @(posedge clk) begin
        if (capture) begin
            arid   <= cmd_id;
            araddr <= cmd_addr;
            arlen  <= cmd_len;
            arsize <= cmd_size;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvld <= 1'b0;
        end else if (capture || reissue) begin
            arvld <= 1'b1;
        end else if (ar_done) begin
            arvld <= 1'b0;
        end
    end

endmodule

// File: rtl/load_beat_if.sv
`timescale 1ns/1ns

interface load_beat_if;
    import lsu_pkg::*;

    logic  rvalid;
    logic  rready;
    word_t rdata;
    resp_t rresp;
    logic  rlast;

    // fsm owns the ready side of the read data channel
    modport fsm_mp (
        input  rvalid,
        input  rlast,
        output rready
    );

    // buffer only observes the channel
    modport buf_mp (
        input rvalid,
        input rready,
        input rdata,
        input rresp,
        input rlast
    );

endinterface

// File: rtl/load_fsm.sv
`timescale 1ns/1ns

module load_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic cmd_vld,
    input  logic burst_bad,
    input  logic commit_last,
    input  logic retry_exhausted,
    input  logic ar_done,
    output logic capture,
    output logic reissue,
    output logic clear_beats,
    output logic commit_en,
    output logic beat_fire,
    output logic busy,
    output logic load_done,
    output logic load_err,
    load_beat_if.fsm_mp beat
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_REQUEST = 3'd1;
    localparam logic [2:0] ST_RECEIVE = 3'd2;
    localparam logic [2:0] ST_COMMIT  = 3'd3;
    localparam logic [2:0] ST_FINISH  = 3'd4;

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       err_q;
    logic       last_fire;

    // finish is the done cycle, so busy is already low there
    assign busy = (state == ST_REQUEST) || (state == ST_RECEIVE) || (state == ST_COMMIT);

    assign capture     = cmd_vld && !busy;
    assign beat.rready = (state == ST_RECEIVE);
    assign beat_fire   = beat.rready && beat.rvalid;
    assign last_fire   = beat_fire && beat.rlast;

    // bad burst goes back to request while retries remain
    assign reissue     = last_fire && burst_bad && !retry_exhausted;
    assign clear_beats = last_fire;
    assign commit_en   = (state == ST_COMMIT);

    assign load_done = (state == ST_FINISH);
    assign load_err  = (state == ST_FINISH) && err_q;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_FINISH: begin
                state_nxt = capture ? ST_REQUEST : ST_IDLE;
            end
            ST_REQUEST: begin
                if (ar_done) begin
                    state_nxt = ST_RECEIVE;
                end
            end
            ST_RECEIVE: begin
                if (last_fire) begin
                    if (!burst_bad) begin
                        state_nxt = ST_COMMIT;
                    end else if (retry_exhausted) begin
                        state_nxt = ST_FINISH;
                    end else begin
                        state_nxt = ST_REQUEST;
                    end
                end
            end
            ST_COMMIT: begin
                if (commit_last) begin
                    state_nxt = ST_FINISH;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // error only when the last attempt still failed
            if (last_fire) begin
                err_q <= burst_bad && retry_exhausted;
            end
        end
    end

endmodule

// File: rtl/load_unit_top.sv
`timescale 1ns/1ns

module load_unit_top #(
    parameter int BURST_MAX  = 16,
    parameter int MAX_RETRY  = 3,
    parameter int SRAM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ctrl_load_vld,
    input  lsu_pkg::id_t    ctrl_load_id,
    input  lsu_pkg::daddr_t ctrl_load_dram_addr,
    input  lsu_pkg::len_t   ctrl_load_len,
    input  lsu_pkg::size_t  ctrl_load_size,
    input  lsu_pkg::saddr_t ctrl_load_sram_addr,
    input  lsu_pkg::bank_t  ctrl_load_sram_type,
    input  logic            axi_arready,
    input  logic            axi_rvalid,
    input  lsu_pkg::word_t  axi_rdata,
    input  lsu_pkg::resp_t  axi_rresp,
    input  logic            axi_rlast,
    input  logic            rd_en,
    input  lsu_pkg::bank_t  rd_bank,
    input  lsu_pkg::saddr_t rd_addr,
    output logic            axi_arvld,
    output lsu_pkg::id_t    axi_arid,
    output lsu_pkg::daddr_t axi_araddr,
    output lsu_pkg::len_t   axi_arlen,
    output lsu_pkg::size_t  axi_arsize,
    output logic            axi_rready,
    output logic            busy,
    output logic            load_done,
    output logic            load_err,
    output lsu_pkg::id_t    load_done_id,
    output lsu_pkg::word_t  rd_data
);
    import lsu_pkg::*;

    localparam int SLOT_W = $clog2(BURST_MAX);

    logic              capture;
    logic              reissue;
    logic              clear_beats;
    logic              commit_en;
    logic              beat_fire;
    logic              ar_done;
    logic              burst_bad;
    logic              commit_last;
    logic              retry_exhausted;
    logic [SLOT_W-1:0] slot;
    len_t              len_q;
    logic              sram_we;
    bank_t             sram_bank;
    saddr_t            sram_addr;
    word_t             sram_wdata;

    load_beat_if beat_if ();

    // read data channel into the interface
    assign beat_if.rvalid = axi_rvalid;
    assign beat_if.rdata  = axi_rdata;
    assign beat_if.rresp  = axi_rresp;
    assign beat_if.rlast  = axi_rlast;
    assign axi_rready     = beat_if.rready;

    // id of the request still held while done is up
    assign load_done_id = axi_arid;

    load_fsm u_load_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_vld         (ctrl_load_vld),
        .burst_bad       (burst_bad),
        .commit_last     (commit_last),
        .retry_exhausted (retry_exhausted),
        .ar_done         (ar_done),
        .capture         (capture),
        .reissue         (reissue),
        .clear_beats     (clear_beats),
        .commit_en       (commit_en),
        .beat_fire       (beat_fire),
        .busy            (busy),
        .load_done       (load_done),
        .load_err        (load_err),
        .beat            (beat_if.fsm_mp)
    );

    beat_counter #(
        .BURST_MAX (BURST_MAX),
        .MAX_RETRY (MAX_RETRY)
    ) u_beat_counter (
        .clk             (clk),
        .rst_n           (rst_n),
        .clear_beats     (clear_beats),
        .start           (capture),
        .beat_fire       (beat_fire),
        .commit_en       (commit_en),
        .reissue         (reissue),
        .len_q           (len_q),
        .slot            (slot),
        .commit_last     (commit_last),
        .retry_exhausted (retry_exhausted)
    );

    load_addr_gen u_load_addr_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .reissue  (reissue),
        .cmd_id   (ctrl_load_id),
        .cmd_addr (ctrl_load_dram_addr),
        .cmd_len  (ctrl_load_len),
        .cmd_size (ctrl_load_size),
        .arready  (axi_arready),
        .arvld    (axi_arvld),
        .arid     (axi_arid),
        .araddr   (axi_araddr),
        .arlen    (axi_arlen),
        .arsize   (axi_arsize),
        .ar_done  (ar_done),
        .len_q    (len_q)
    );

    burst_buffer #(
        .BURST_MAX (BURST_MAX)
    ) u_burst_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture       (capture),
        .cmd_sram_addr (ctrl_load_sram_addr),
        .cmd_sram_bank (ctrl_load_sram_type),
        .clear_beats   (clear_beats),
        .commit_en     (commit_en),
        .slot          (slot),
        .beat          (beat_if.buf_mp),
        .burst_bad     (burst_bad),
        .sram_we       (sram_we),
        .sram_bank     (sram_bank),
        .sram_addr     (sram_addr),
        .sram_wdata    (sram_wdata)
    );

    scratch_sram #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) u_scratch_sram (
        .clk     (clk),
        .we      (sram_we),
        .wbank   (sram_bank),
        .waddr   (sram_addr),
        .wdata   (sram_wdata),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

    // transaction id carried on the read address channel
    typedef logic [7:0]  id_t;

    // dram side word address
    typedef logic [11:0] daddr_t;

    // scratchpad word address inside one bank
    typedef logic [7:0]  saddr_t;

    typedef logic [31:0] word_t;

    // four scratchpad banks
    typedef logic [1:0]  bank_t;

    // burst length, beats minus one
    typedef logic [7:0]  len_t;

    typedef logic [2:0]  size_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

endpackage

// File: rtl/scratch_sram.sv
`timescale 1ns/1ns

module scratch_sram #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            we,
    input  lsu_pkg::bank_t  wbank,
    input  lsu_pkg::saddr_t waddr,
    input  lsu_pkg::word_t  wdata,
    input  logic            rd_en,
    input  lsu_pkg::bank_t  rd_bank,
    input  lsu_pkg::saddr_t rd_addr,
    output lsu_pkg::word_t  rd_data
);
    import lsu_pkg::*;

    localparam int NUM_BANKS = 2 ** $bits(bank_t);

    word_t mem [NUM_BANKS][SRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wbank][waddr] <= wdata;
        end
    end

    // registered read, one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank][rd_addr];
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the load unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module load_unit_tb \
    -f all.f \
    -o load_unit_sim

./obj_dir/load_unit_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "load unit simulation failed, see sim.log"
    exit 1
fi

echo "load unit simulation passed"

// File: verification/axi_dram_model.sv
`timescale 1ns/1ns

module axi_dram_model (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            arvld,
    input  lsu_pkg::daddr_t araddr,
    input  lsu_pkg::len_t   arlen,
    output logic            arready,
    output logic            rvalid,
    output lsu_pkg::word_t  rdata,
    output lsu_pkg::resp_t  rresp,
    output logic            rlast,
    input  logic            rready,
    input  lsu_pkg::word_t  key,
    input  int              err_count,
    input  int              err_beat,
    input  logic            err_load,
    output int              req_count
);
    import lsu_pkg::*;

    logic   ar_fire;
    logic   r_fire;
    logic   rst_s;
    logic   active;
    logic   inject;
    daddr_t ar_addr_s;
    daddr_t base;
    daddr_t beat_addr;
    int     ar_len_s;
    int     last_beat;
    int     beat_idx;
    int     errors_left;

    initial begin
        arready     = 1'b0;
        rvalid      = 1'b0;
        rdata       = '0;
        rresp       = '0;
        rlast       = 1'b0;
        req_count   = 0;
        active      = 1'b0;
        inject      = 1'b0;
        base        = '0;
        last_beat   = 0;
        beat_idx    = 0;
        errors_left = 0;
        forever begin
            // handshakes are settled by the falling edge
            @(negedge clk);
            rst_s     = rst_n;
            ar_fire   = arvld && arready;
            r_fire    = rvalid && rready;
            ar_addr_s = araddr;
            ar_len_s  = int'(arlen);
            if (err_load) begin
                errors_left = err_count;
            end
            @(posedge clk);
            #10;
            if (!rst_s) begin
                active = 1'b0;
                rvalid = 1'b0;
                rlast  = 1'b0;
            end else begin
                if (r_fire) begin
                    if (beat_idx == last_beat) begin
                        active = 1'b0;
                    end else begin
                        beat_idx++;
                    end
                    rvalid = 1'b0;
                end
                if (ar_fire) begin
                    req_count++;
                    base      = ar_addr_s;
                    last_beat = ar_len_s;
                    beat_idx  = 0;
                    active    = 1'b1;
                    // this attempt gets an error beat while the budget lasts
                    inject    = (errors_left > 0);
                    if (inject) begin
                        errors_left--;
                    end
                end
                arready = (($urandom % 4) != 0);
                // a beat on the bus is held until it is taken
                if (active && !rvalid && (($urandom % 3) != 0)) begin
                    beat_addr = base + daddr_t'(beat_idx);
                    rvalid    = 1'b1;
                    rdata     = key ^ {beat_addr, beat_addr[7:0] ^ 8'h5a, beat_addr};
                    rresp     = (inject && (beat_idx == err_beat)) ? 2'b10 : 2'b00;
                    rlast     = (beat_idx == last_beat);
                end
                if (!rvalid) begin
                    rresp = 2'b00;
                    rlast = 1'b0;
                end
            end
        end
    end

endmodule

// File: verification/load_unit_tb.sv
`timescale 1ns/1ns

module load_unit_tb;
    import lsu_pkg::*;

    localparam int BURST_MAX  = 16;
    localparam int MAX_RETRY  = 3;
    localparam int SRAM_DEPTH = 256;
    localparam int SOAK_LOADS = 10;
    // beats and loads over all tests, the watchdog budget follows from them
    localparam int TEST_BEATS = 4 + 8 + 6 + 8 + 2 * 5 + SOAK_LOADS * BURST_MAX;
    localparam int TEST_LOADS = 6 + SOAK_LOADS;
    localparam int WATCHDOG_CYCLES = (TEST_BEATS + 20 * TEST_LOADS) * (MAX_RETRY + 1) * 8;

    logic   clk;
    logic   rst_n;
    logic   ctrl_load_vld;
    id_t    ctrl_load_id;
    daddr_t ctrl_load_dram_addr;
    len_t   ctrl_load_len;
    size_t  ctrl_load_size;
    saddr_t ctrl_load_sram_addr;
    bank_t  ctrl_load_sram_type;
    logic   axi_arready;
    logic   axi_rvalid;
    word_t  axi_rdata;
    resp_t  axi_rresp;
    logic   axi_rlast;
    logic   rd_en;
    bank_t  rd_bank;
    saddr_t rd_addr;
    logic   axi_arvld;
    id_t    axi_arid;
    daddr_t axi_araddr;
    len_t   axi_arlen;
    size_t  axi_arsize;
    logic   axi_rready;
    logic   busy;
    logic   load_done;
    logic   load_err;
    id_t    load_done_id;
    word_t  rd_data;

    word_t  dram_key;
    int     dram_err_count;
    int     dram_err_beat;
    logic   dram_err_load;
    int     req_count;

    // expected scratchpad contents
    word_t  shadow [4][SRAM_DEPTH];
    logic   shadow_vld [4][SRAM_DEPTH];

    string  cur_test;
    int     err_cnt;
    int     test_err_base;
    int     pass_tests;
    int     fail_tests;

    // load in flight
    id_t    exp_id;
    daddr_t exp_addr;
    len_t   exp_len;
    saddr_t exp_saddr;
    bank_t  exp_bank;
    word_t  exp_key;
    logic   exp_err;
    int     exp_reqs;
    int     req_base;
    logic   chk_done;

    load_unit_top #(
        .BURST_MAX  (BURST_MAX),
        .MAX_RETRY  (MAX_RETRY),
        .SRAM_DEPTH (SRAM_DEPTH)
    ) load_unit_top_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .ctrl_load_vld       (ctrl_load_vld),
        .ctrl_load_id        (ctrl_load_id),
        .ctrl_load_dram_addr (ctrl_load_dram_addr),
        .ctrl_load_len       (ctrl_load_len),
        .ctrl_load_size      (ctrl_load_size),
        .ctrl_load_sram_addr (ctrl_load_sram_addr),
        .ctrl_load_sram_type (ctrl_load_sram_type),
        .axi_arready         (axi_arready),
        .axi_rvalid          (axi_rvalid),
        .axi_rdata           (axi_rdata),
        .axi_rresp           (axi_rresp),
        .axi_rlast           (axi_rlast),
        .rd_en               (rd_en),
        .rd_bank             (rd_bank),
        .rd_addr             (rd_addr),
        .axi_arvld           (axi_arvld),
        .axi_arid            (axi_arid),
        .axi_araddr          (axi_araddr),
        .axi_arlen           (axi_arlen),
        .axi_arsize          (axi_arsize),
        .axi_rready          (axi_rready),
        .busy                (busy),
        .load_done           (load_done),
        .load_err            (load_err),
        .load_done_id        (load_done_id),
        .rd_data             (rd_data)
    );

    axi_dram_model dram_model_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvld     (axi_arvld),
        .araddr    (axi_araddr),
        .arlen     (axi_arlen),
        .arready   (axi_arready),
        .rvalid    (axi_rvalid),
        .rdata     (axi_rdata),
        .rresp     (axi_rresp),
        .rlast     (axi_rlast),
        .rready    (axi_rready),
        .key       (dram_key),
        .err_count (dram_err_count),
        .err_beat  (dram_err_beat),
        .err_load  (dram_err_load),
        .req_count (req_count)
    );

    // data the dram returns for one word address
    function automatic word_t expected_word(input word_t key, input daddr_t addr);
        return key ^ {addr, addr[7:0] ^ 8'h5a, addr};
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic readback_region(input bank_t bank, input saddr_t base, input int count);
        saddr_t a;
        int     i;
        for (i = 0; i < count; i++) begin
            a = base + saddr_t'(i);
            if (shadow_vld[bank][a]) begin
                @(posedge clk);
                #10;
                rd_en   = 1'b1;
                rd_bank = bank;
                rd_addr = a;
                @(posedge clk);
                #10;
                rd_en = 1'b0;
                check_value($sformatf("bank %0d word %h", bank, a), shadow[bank][a], rd_data);
            end
        end
    endtask

    task automatic start_load(input id_t id, input daddr_t addr, input len_t len,
                              input saddr_t saddr, input bank_t bank, input word_t key,
                              input int errs, input int ebeat, input logic err_exp,
                              input int reqs_exp);
        exp_id         = id;
        exp_addr       = addr;
        exp_len        = len;
        exp_saddr      = saddr;
        exp_bank       = bank;
        exp_key        = key;
        exp_err        = err_exp;
        exp_reqs       = reqs_exp;
        req_base       = req_count;
        chk_done       = 1'b0;
        dram_key       = key;
        dram_err_count = errs;
        dram_err_beat  = ebeat;
        @(posedge clk);
        #10;
        ctrl_load_vld       = 1'b1;
        ctrl_load_id        = id;
        ctrl_load_dram_addr = addr;
        ctrl_load_len       = len;
        ctrl_load_sram_addr = saddr;
        ctrl_load_sram_type = bank;
        dram_err_load       = 1'b1;
        @(posedge clk);
        #10;
        ctrl_load_vld = 1'b0;
        dram_err_load = 1'b0;
    endtask

    task automatic wait_load();
        while (!chk_done) begin
            @(posedge clk);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == test_err_base) begin
            pass_tests++;
            $display("test %s: passed", cur_test);
        end else begin
            fail_tests++;
            $display("test %s: failed with %0d errors", cur_test, err_cnt - test_err_base);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // every request must carry the fields of the load in flight
    initial begin
        forever begin
            @(negedge clk);
            if (axi_arvld && axi_arready) begin
                check_value("arid", 32'(exp_id), 32'(axi_arid));
                check_value("araddr", 32'(exp_addr), 32'(axi_araddr));
                check_value("arlen", 32'(exp_len), 32'(axi_arlen));
                check_value("arsize", 32'd2, 32'(axi_arsize));
            end
        end
    end

    // compare on every done pulse, then read the target region back
    initial begin
        logic   got_err;
        id_t    got_id;
        int     reqs;
        int     i;
        saddr_t a;
        forever begin
            @(negedge clk);
            if (load_done) begin
                got_err = load_err;
                got_id  = load_done_id;
                reqs    = req_count - req_base;
                check_value("load_err", 32'(exp_err), 32'(got_err));
                check_value("load_done_id", 32'(exp_id), 32'(got_id));
                check_value("request count", 32'(exp_reqs), 32'(reqs));
                if (!exp_err) begin
                    for (i = 0; i <= int'(exp_len); i++) begin
                        a = exp_saddr + saddr_t'(i);
                        shadow[exp_bank][a]     = expected_word(exp_key, exp_addr + daddr_t'(i));
                        shadow_vld[exp_bank][a] = 1'b1;
                    end
                end
                readback_region(exp_bank, exp_saddr, int'(exp_len) + 1);
                chk_done = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the load tests did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int b;
        int w;
        int n;
        void'($urandom(32'h0edb1dda));
        rst_n               = 1'b0;
        ctrl_load_vld       = 1'b0;
        ctrl_load_id        = '0;
        ctrl_load_dram_addr = '0;
        ctrl_load_len       = '0;
        ctrl_load_size      = 3'd2;
        ctrl_load_sram_addr = '0;
        ctrl_load_sram_type = '0;
        rd_en               = 1'b0;
        rd_bank             = '0;
        rd_addr             = '0;
        dram_key            = '0;
        dram_err_count      = 0;
        dram_err_beat       = 0;
        dram_err_load       = 1'b0;
        err_cnt             = 0;
        pass_tests          = 0;
        fail_tests          = 0;
        chk_done            = 1'b0;
        req_base            = 0;
        for (b = 0; b < 4; b++) begin
            for (w = 0; w < SRAM_DEPTH; w++) begin
                shadow_vld[b][w] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        begin_test("reset_and_busy");
        @(negedge clk);
        check_value("arvld after reset", 32'd0, 32'(axi_arvld));
        check_value("rready after reset", 32'd0, 32'(axi_rready));
        check_value("busy after reset", 32'd0, 32'(busy));
        check_value("load_done after reset", 32'd0, 32'(load_done));
        start_load(8'h11, 12'h040, 8'd3, 8'h10, 2'd0, 32'h1111_0000, 0, 0, 1'b0, 1);
        @(negedge clk);
        check_value("busy after command", 32'd1, 32'(busy));
        // second strobe while busy, must not reach the bus
        @(posedge clk);
        #10;
        ctrl_load_vld       = 1'b1;
        ctrl_load_id        = 8'h99;
        ctrl_load_dram_addr = 12'h300;
        @(posedge clk);
        #10;
        ctrl_load_vld = 1'b0;
        wait_load();
        end_test();

        begin_test("clean_burst");
        start_load(8'h22, 12'h100, 8'd7, 8'h40, 2'd1, 32'hc0de_2222, 0, 0, 1'b0, 1);
        wait_load();
        end_test();

        // error on the last beat of the first attempt only
        begin_test("single_bad_attempt");
        start_load(8'h33, 12'h2f8, 8'd5, 8'h80, 2'd2, 32'h3333_abcd, 1, 5, 1'b0, 2);
        wait_load();
        end_test();

        // same region as the clean burst, which must survive
        begin_test("retries_exhausted");
        start_load(8'h44, 12'h500, 8'd7, 8'h40, 2'd1, 32'h4444_f00d, MAX_RETRY + 1, 2,
                   1'b1, MAX_RETRY + 1);
        wait_load();
        end_test();

        begin_test("bank_separation");
        start_load(8'h55, 12'h600, 8'd4, 8'hc0, 2'd0, 32'h5555_0001, 0, 0, 1'b0, 1);
        wait_load();
        start_load(8'h56, 12'h700, 8'd4, 8'hc0, 2'd3, 32'h5656_0002, 0, 0, 1'b0, 1);
        wait_load();
        readback_region(2'd0, 8'hc0, 5);
        end_test();

        begin_test("backpressure_soak");
        for (n = 0; n < SOAK_LOADS; n++) begin
            start_load(id_t'($urandom), daddr_t'($urandom), len_t'($urandom % BURST_MAX),
                       saddr_t'($urandom), bank_t'($urandom), word_t'($urandom),
                       0, 0, 1'b0, 1);
            wait_load();
        end
        end_test();

        $display("tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
